// ==== Makefile ====
TOP = tb_ex

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f --Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

// ==== bench/ex_asserts.sv ====
module ex_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input ex_isa_pkg::reg_idx_t  dest_i,
    input logic                  overflow_i,
    input logic                  priv_i,
    input ex_mem_pkg::mem_type_e mem_type_i,
    input ex_isa_pkg::word_t     mem_addr_i
);
    import ex_mem_pkg::*;

    // a trapping add never names a destination
    ovf_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        overflow_i |-> dest_i == '0)
        else $error("overflow_o high with dest_o %0d", dest_i);

    // no access means a zero address
    idle_addr_zero: assert property (@(posedge clk) disable iff (!rst_n)
        mem_type_i == MEM_R2R |-> mem_addr_i == '0)
        else $error("mem_addr_o %h without a memory access", mem_addr_i);

    priv_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        priv_i |-> dest_i == '0)
        else $error("priv_o high with dest_o %0d", dest_i);

endmodule

bind ex_top ex_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .dest_i     (dest_o),
    .overflow_i (overflow_o),
    .priv_i     (priv_o),
    .mem_type_i (mem_type_o),
    .mem_addr_i (mem_addr_o)
);

// ==== bench/tb_ex.sv ====
module tb_ex;
    import ex_isa_pkg::*;
    import ex_mem_pkg::*;

    localparam int TIMEOUT = 20;

    logic        clk;
    logic        rst_n;
    op_e         op;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    word_t       rs_val;
    word_t       rt_val;
    logic [15:0] imm;
    logic [4:0]  shamt;
    word_t       link_addr;

    word_t       result;
    reg_idx_t    dest;
    logic        overflow;
    logic        priv;
    mem_type_e   mem_type;
    mem_size_e   mem_size;
    logic        mem_signed;
    word_t       mem_addr;

    int cycle = 0;
    int n_checks;
    int n_errors;

    ex_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_i         (op),
        .rs_i         (rs),
        .rt_i         (rt),
        .rd_i         (rd),
        .rs_val_i     (rs_val),
        .rt_val_i     (rt_val),
        .imm_i        (imm),
        .shamt_i      (shamt),
        .link_addr_i  (link_addr),
        .result_o     (result),
        .dest_o       (dest),
        .overflow_o   (overflow),
        .priv_o       (priv),
        .mem_type_o   (mem_type),
        .mem_size_o   (mem_size),
        .mem_signed_o (mem_signed),
        .mem_addr_o   (mem_addr)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // returns one time unit after the n-th rising edge
    task automatic wait_cycles(input int n);
        int start;
        int guard;
        start = cycle;
        guard = 0;
        while ((cycle - start) < n && guard < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            guard++;
        end
        if ((cycle - start) < n)
        begin
            $display("Timeout: waited %0d cycles for %0d clock edges", guard, n);
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic issue(input op_e o, input word_t a, input word_t b,
                         input logic [15:0] i, input logic [4:0] s);
        op     = o;
        rs_val = a;
        rt_val = b;
        imm    = i;
        shamt  = s;
        wait_cycles(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_type(input string name, input mem_type_e got,
                                  input mem_type_e exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s = %s, expected %s", $time, name,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_mem_size(input string name, input mem_size_e got,
                                  input mem_size_e exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s = %s, expected %s", $time, name,
                     got.name(), exp.name());
        end
    endtask

    // reference results from the instruction set rules
    function automatic word_t model_alu(input op_e o, input word_t a, input word_t b,
                                        input logic [15:0] i, input logic [4:0] s);
        word_t simm;
        word_t uimm;
        simm = {{16{i[15]}}, i};
        uimm = {16'h0, i};
        case (o)
            OP_ADD, OP_ADDU:   return a + b;
            OP_ADDI, OP_ADDIU: return a + simm;
            OP_SUB, OP_SUBU:   return a - b;
            OP_SLT:            return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTI:           return ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTU:           return (a < b) ? 32'd1 : 32'd0;
            OP_SLTIU:          return (a < simm) ? 32'd1 : 32'd0;
            OP_AND:            return a & b;
            OP_ANDI:           return a & uimm;
            OP_OR:             return a | b;
            OP_ORI:            return a | uimm;
            OP_XOR:            return a ^ b;
            OP_XORI:           return a ^ uimm;
            OP_NOR:            return ~(a | b);
            OP_LUI:            return {i, 16'h0};
            OP_SLL:            return b << s;
            OP_SLLV:           return b << a[4:0];
            OP_SRL:            return b >> s;
            OP_SRLV:           return b >> a[4:0];
            OP_SRA:            return word_t'($signed(b) >>> s);
            OP_SRAV:           return word_t'($signed(b) >>> a[4:0]);
            default:           return '0;
        endcase
    endfunction

    // true sum outside the 32-bit signed range
    function automatic logic expect_ovf(input op_e o, input word_t a, input word_t b,
                                        input logic [15:0] i);
        longint x;
        longint r;
        x = longint'($signed(a));
        case (o)
            OP_ADD:  r = x + longint'($signed(b));
            OP_ADDI: r = x + longint'($signed(i));
            OP_SUB:  r = x - longint'($signed(b));
            default: r = 0;
        endcase
        return (r > 64'sd2147483647) || (r < -64'sd2147483648);
    endfunction

    function automatic logic is_imm_form(input op_e o);
        return o inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    endfunction

    function automatic word_t count_leading(input word_t v, input logic bitval);
        int    k;
        word_t n;
        k = 31;
        n = '0;
        while (k >= 0 && v[k] == bitval)
        begin
            n = n + 32'd1;
            k = k - 1;
        end
        return n;
    endfunction

    task automatic test_reset;
        check_word("result_o", result, '0);
        check_reg("dest_o", dest, '0);
        check_bit("overflow_o", overflow, 1'b0);
        check_bit("priv_o", priv, 1'b0);
        check_mem_type("mem_type_o", mem_type, MEM_R2R);
        check_mem_size("mem_size_o", mem_size, SIZE_WORD);
        check_bit("mem_signed_o", mem_signed, 1'b1);
        check_word("mem_addr_o", mem_addr, '0);
    endtask

    task automatic test_arith;
        op_e   ops[$];
        word_t a;
        word_t b;
        word_t r;
        logic  ov;
        ops = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_ADDI, OP_ADDIU,
                OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU, OP_AND, OP_ANDI, OP_OR, OP_ORI,
                OP_XOR, OP_XORI, OP_NOR, OP_LUI, OP_SLL, OP_SLLV, OP_SRL, OP_SRLV,
                OP_SRA, OP_SRAV};
        for (int n = 0; n < 8; n++)
        begin
            a = $urandom;
            b = $urandom;
            r = $urandom;
            foreach (ops[k])
            begin
                issue(ops[k], a, b, r[15:0], r[20:16]);
                ov = expect_ovf(ops[k], a, b, r[15:0]);
                check_bit("overflow_o", overflow, ov);
                if (ov)
                    check_reg("dest_o", dest, '0);
                else
                begin
                    check_word("result_o", result, model_alu(ops[k], a, b, r[15:0], r[20:16]));
                    check_reg("dest_o", dest, is_imm_form(ops[k]) ? rt : rd);
                end
            end
        end
        // operands at the signed limits
        issue(OP_ADD, 32'h7fff_ffff, 32'h1, 16'h0, 5'd0);
        check_bit("overflow_o", overflow, 1'b1);
        check_reg("dest_o", dest, '0);
        issue(OP_SUB, 32'h8000_0000, 32'h1, 16'h0, 5'd0);
        check_bit("overflow_o", overflow, 1'b1);
        check_reg("dest_o", dest, '0);
        issue(OP_ADDI, 32'h7fff_fff0, 32'h0, 16'h0010, 5'd0);
        check_bit("overflow_o", overflow, 1'b1);
        check_reg("dest_o", dest, '0);
        issue(OP_ADDU, 32'h7fff_ffff, 32'h1, 16'h0, 5'd0);
        check_bit("overflow_o", overflow, 1'b0);
        check_word("result_o", result, 32'h8000_0000);
        issue(OP_ADDIU, 32'h7fff_fff0, 32'h0, 16'h0010, 5'd0);
        check_bit("overflow_o", overflow, 1'b0);
        check_reg("dest_o", dest, rt);
        issue(OP_SUBU, 32'h8000_0000, 32'h1, 16'h0, 5'd0);
        check_bit("overflow_o", overflow, 1'b0);
        check_word("result_o", result, 32'h7fff_ffff);
    endtask

    task automatic test_counts;
        word_t pats[$];
        pats = '{32'h0, 32'hffff_ffff, 32'h1, 32'h0001_0000, 32'hf000_0000,
                 32'h8000_0000, 32'h7fff_ffff};
        foreach (pats[k])
        begin
            issue(OP_CLZ, pats[k], 32'h0, 16'h0, 5'd0);
            check_word("result_o", result, count_leading(pats[k], 1'b0));
            check_reg("dest_o", dest, rd);
            issue(OP_CLO, pats[k], 32'h0, 16'h0, 5'd0);
            check_word("result_o", result, count_leading(pats[k], 1'b1));
            check_reg("dest_o", dest, rd);
        end
        // movz writes on rt zero and movn on rt nonzero
        issue(OP_MOVZ, 32'hcafe_0001, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'hcafe_0001);
        check_reg("dest_o", dest, rd);
        issue(OP_MOVZ, 32'hcafe_0002, 32'h5, 16'h0, 5'd0);
        check_reg("dest_o", dest, '0);
        issue(OP_MOVN, 32'hcafe_0003, 32'h5, 16'h0, 5'd0);
        check_word("result_o", result, 32'hcafe_0003);
        check_reg("dest_o", dest, rd);
        issue(OP_MOVN, 32'hcafe_0004, 32'h0, 16'h0, 5'd0);
        check_reg("dest_o", dest, '0);
    endtask

    task automatic test_mul;
        word_t       a;
        word_t       b;
        logic [63:0] sprod;
        logic [63:0] uprod;
        // nothing has written hilo since reset
        issue(OP_MFHI, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h0);
        issue(OP_MFLO, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h0);
        for (int n = 0; n < 6; n++)
        begin
            a = $urandom;
            b = $urandom;
            sprod = longint'($signed(a)) * longint'($signed(b));
            uprod = {32'h0, a} * {32'h0, b};
            issue(OP_MUL, a, b, 16'h0, 5'd0);
            check_word("result_o", result, sprod[31:0]);
            check_reg("dest_o", dest, rd);
            issue(OP_MULT, a, b, 16'h0, 5'd0);
            check_reg("dest_o", dest, '0);
            issue(OP_MFHI, 32'h0, 32'h0, 16'h0, 5'd0);
            check_word("result_o", result, sprod[63:32]);
            check_reg("dest_o", dest, rd);
            issue(OP_MFLO, 32'h0, 32'h0, 16'h0, 5'd0);
            check_word("result_o", result, sprod[31:0]);
            issue(OP_MULTU, a, b, 16'h0, 5'd0);
            check_reg("dest_o", dest, '0);
            issue(OP_MFHI, 32'h0, 32'h0, 16'h0, 5'd0);
            check_word("result_o", result, uprod[63:32]);
            issue(OP_MFLO, 32'h0, 32'h0, 16'h0, 5'd0);
            check_word("result_o", result, uprod[31:0]);
        end
        // each move-to leaves the other half alone
        issue(OP_MTHI, 32'h1234_5678, 32'h0, 16'h0, 5'd0);
        check_reg("dest_o", dest, '0);
        issue(OP_MFLO, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, uprod[31:0]);
        issue(OP_MFHI, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h1234_5678);
        issue(OP_MTLO, 32'h9abc_def0, 32'h0, 16'h0, 5'd0);
        check_reg("dest_o", dest, '0);
        issue(OP_MFHI, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h1234_5678);
        issue(OP_MFLO, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h9abc_def0);
    endtask

    task automatic test_mem;
        op_e       ops[$];
        word_t     a;
        word_t     r;
        mem_type_e t;
        mem_size_e sz;
        ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
                OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
        foreach (ops[k])
        begin
            a = $urandom;
            r = $urandom;
            t = (ops[k] inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR}) ? MEM_R2M : MEM_M2R;
            case (ops[k])
                OP_LB, OP_LBU, OP_SB: sz = SIZE_BYTE;
                OP_LH, OP_LHU, OP_SH: sz = SIZE_HALF;
                OP_LWL, OP_SWL:       sz = SIZE_LEFT;
                OP_LWR, OP_SWR:       sz = SIZE_RIGHT;
                default:              sz = SIZE_WORD;
            endcase
            issue(ops[k], a, r ^ 32'h5a5a_5a5a, r[15:0], 5'd0);
            check_word("mem_addr_o", mem_addr, a + {{16{r[15]}}, r[15:0]});
            check_mem_type("mem_type_o", mem_type, t);
            check_mem_size("mem_size_o", mem_size, sz);
            check_bit("mem_signed_o", mem_signed, !(ops[k] == OP_LBU || ops[k] == OP_LHU));
            check_word("result_o", result, r ^ 32'h5a5a_5a5a);
            check_reg("dest_o", dest, (t == MEM_R2M) ? 5'd0 : rt);
            // a plain add drops the access again
            issue(OP_ADD, 32'h10, 32'h20, 16'h0, 5'd0);
            check_mem_type("mem_type_o", mem_type, MEM_R2R);
            check_word("mem_addr_o", mem_addr, '0);
            check_word("result_o", result, 32'h30);
        end
    endtask

    task automatic test_link_priv;
        op_e ops[$];
        link_addr = 32'h0040_0108;
        issue(OP_JAL, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h0040_0108);
        check_reg("dest_o", dest, 5'd31);
        issue(OP_JALR, 32'h0, 32'h0, 16'h0, 5'd0);
        check_word("result_o", result, 32'h0040_0108);
        check_reg("dest_o", dest, rd);
        ops = '{OP_MFC0, OP_ERET, OP_MTC0, OP_WAIT, OP_TLBWI, OP_TLBP};
        foreach (ops[k])
        begin
            issue(ops[k], 32'h1, 32'h2, 16'h0, 5'd0);
            check_bit("priv_o", priv, 1'b1);
            check_reg("dest_o", dest, '0);
        end
        issue(OP_NOP, 32'h0, 32'h0, 16'h0, 5'd0);
        check_bit("priv_o", priv, 1'b0);
        check_reg("dest_o", dest, '0);
    endtask

    initial
    begin
        void'($urandom(59027));
        clk       = 1'b0;
        rst_n     = 1'b0;
        op        = OP_NOP;
        rs        = 5'd4;
        rt        = 5'd9;
        rd        = 5'd17;
        rs_val    = '0;
        rt_val    = '0;
        imm       = '0;
        shamt     = '0;
        link_addr = '0;
        n_checks  = 0;
        n_errors  = 0;

        wait_cycles(2);
        test_reset();
        rst_n = 1'b1;

        test_arith();
        test_counts();
        test_mul();
        test_mem();
        test_link_priv();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/ex_isa_pkg.sv
rtl/ex_mem_pkg.sv
rtl/ex_op_if.sv
rtl/ex_alu.sv
rtl/ex_mul.sv
rtl/ex_hilo.sv
rtl/ex_agen.sv
rtl/ex_writeback.sv
rtl/ex_top.sv
bench/ex_asserts.sv
bench/tb_ex.sv

// ==== rtl/ex_agen.sv ====
module ex_agen (
    input  logic                  clk,
    input  logic                  rst_n,
    ex_op_if.use_alu              op_bus,
    output ex_mem_pkg::mem_type_e mem_type_o,
    output ex_mem_pkg::mem_size_e mem_size_o,
    output logic                  mem_signed_o,
    output ex_isa_pkg::word_t     mem_addr_o
);
    import ex_isa_pkg::*;
    import ex_mem_pkg::*;

    mem_type_e nxt_type;
    mem_size_e nxt_size;
    logic      nxt_signed;
    word_t     eff_addr;

    assign eff_addr = op_bus.rs_val + {{16{op_bus.imm[15]}}, op_bus.imm};

    always_comb
    begin
        case (op_bus.op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR:
                nxt_type = MEM_M2R;
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR:
                nxt_type = MEM_R2M;
            default:
                nxt_type = MEM_R2R;
        endcase

        case (op_bus.op)
            OP_LB, OP_LBU, OP_SB:
                nxt_size = SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH:
                nxt_size = SIZE_HALF;
            OP_LWL, OP_SWL:
                nxt_size = SIZE_LEFT;
            OP_LWR, OP_SWR:
                nxt_size = SIZE_RIGHT;
            default:
                nxt_size = SIZE_WORD;
        endcase

        // only the unsigned loads skip sign extension
        nxt_signed = !(op_bus.op inside {OP_LBU, OP_LHU});
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || nxt_type == MEM_R2R)
        begin
            mem_type_o   <= MEM_R2R;
            mem_size_o   <= SIZE_WORD;
            mem_signed_o <= 1'b1;
            mem_addr_o   <= '0;
        end
        else
        begin
            mem_type_o   <= nxt_type;
            mem_size_o   <= nxt_size;
            mem_signed_o <= nxt_signed;
            mem_addr_o   <= eff_addr;
        end
    end

endmodule

// ==== rtl/ex_alu.sv ====
module ex_alu (
    ex_op_if.use_alu          op_bus,
    output ex_isa_pkg::word_t alu_val_o,
    output logic              alu_wr_o,
    output logic              alu_ov_o
);
    import ex_isa_pkg::*;

    word_t      sext_imm;
    word_t      zext_imm;
    word_t      opnd_b;
    word_t      sum;
    word_t      diff;
    logic       add_ov;
    logic       sub_ov;
    logic [4:0] var_sh;

    // number of leading zero bits, 32 for an all-zero word
    function automatic logic [5:0] lead_zeros(input word_t v);
        logic [5:0] n;
        logic       hit;
        n   = '0;
        hit = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (v[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 6'd1;
        end
        return n;
    endfunction

    assign sext_imm = {{16{op_bus.imm[15]}}, op_bus.imm};
    assign zext_imm = {16'b0, op_bus.imm};

    // add and compare immediates replace rt
    assign opnd_b = (op_bus.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) ?
                    sext_imm : op_bus.rt_val;

    assign sum  = op_bus.rs_val + opnd_b;
    assign diff = op_bus.rs_val - opnd_b;

    // signed overflow, operand signs vs result sign
    assign add_ov = (op_bus.rs_val[31] == opnd_b[31]) && (sum[31] != op_bus.rs_val[31]);
    assign sub_ov = (op_bus.rs_val[31] != opnd_b[31]) && (diff[31] != op_bus.rs_val[31]);

    assign var_sh = op_bus.rs_val[4:0];

    always_comb
    begin
        alu_val_o = '0;
        alu_wr_o  = 1'b1;
        alu_ov_o  = 1'b0;
        case (op_bus.op)
            OP_ADD, OP_ADDI:
            begin
                alu_val_o = sum;
                alu_ov_o  = add_ov;
            end
            OP_ADDU, OP_ADDIU:
                alu_val_o = sum;
            OP_SUB:
            begin
                alu_val_o = diff;
                alu_ov_o  = sub_ov;
            end
            OP_SUBU:
                alu_val_o = diff;
            OP_SLT, OP_SLTI:
                alu_val_o = {31'b0, $signed(op_bus.rs_val) < $signed(opnd_b)};
            OP_SLTU, OP_SLTIU:
                alu_val_o = {31'b0, op_bus.rs_val < opnd_b};
            OP_AND:
                alu_val_o = op_bus.rs_val & op_bus.rt_val;
            OP_ANDI:
                alu_val_o = op_bus.rs_val & zext_imm;
            OP_OR:
                alu_val_o = op_bus.rs_val | op_bus.rt_val;
            OP_ORI:
                alu_val_o = op_bus.rs_val | zext_imm;
            OP_XOR:
                alu_val_o = op_bus.rs_val ^ op_bus.rt_val;
            OP_XORI:
                alu_val_o = op_bus.rs_val ^ zext_imm;
            OP_NOR:
                alu_val_o = ~(op_bus.rs_val | op_bus.rt_val);
            OP_LUI:
                alu_val_o = {op_bus.imm, 16'b0};
            OP_SLL:
                alu_val_o = op_bus.rt_val << op_bus.shamt;
            OP_SLLV:
                alu_val_o = op_bus.rt_val << var_sh;
            OP_SRL:
                alu_val_o = op_bus.rt_val >> op_bus.shamt;
            OP_SRLV:
                alu_val_o = op_bus.rt_val >> var_sh;
            OP_SRA:
                alu_val_o = word_t'($signed(op_bus.rt_val) >>> op_bus.shamt);
            OP_SRAV:
                alu_val_o = word_t'($signed(op_bus.rt_val) >>> var_sh);
            OP_CLZ:
                alu_val_o = {26'b0, lead_zeros(op_bus.rs_val)};
            // leading ones are leading zeros of the inverse
            OP_CLO:
                alu_val_o = {26'b0, lead_zeros(~op_bus.rs_val)};
            OP_MOVZ:
            begin
                alu_val_o = op_bus.rs_val;
                alu_wr_o  = (op_bus.rt_val == '0);
            end
            OP_MOVN:
            begin
                alu_val_o = op_bus.rs_val;
                alu_wr_o  = (op_bus.rt_val != '0);
            end
            default:
                alu_val_o = '0;
        endcase
        // trapping overflow cancels the write
        if (alu_ov_o)
            alu_wr_o = 1'b0;
    end

endmodule

// ==== rtl/ex_hilo.sv ====
module ex_hilo (
    input  logic                          clk,
    input  logic                          rst_n,
    ex_op_if.use_alu                      op_bus,
    input  logic [ex_isa_pkg::HILO_W-1:0] product_i,
    output ex_isa_pkg::word_t             hi_o,
    output ex_isa_pkg::word_t             lo_o
);
    import ex_isa_pkg::*;

    logic [HILO_W-1:0] hilo;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hilo <= '0;
        end
        else
        begin
            case (op_bus.op)
                OP_MULT, OP_MULTU:
                    hilo <= product_i;
                // move-to touches one half only
                OP_MTHI:
                    hilo[HILO_W-1:HILO_W/2] <= op_bus.rs_val;
                OP_MTLO:
                    hilo[HILO_W/2-1:0] <= op_bus.rs_val;
                default:
                    hilo <= hilo;
            endcase
        end
    end

    // read straight off the register so mfhi/mflo see last cycle's write
    assign hi_o = hilo[HILO_W-1:HILO_W/2];
    assign lo_o = hilo[HILO_W/2-1:0];

endmodule

// ==== rtl/ex_isa_pkg.sv ====
package ex_isa_pkg;

    localparam int WORD_W = 32;
    localparam int HILO_W = 64;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        reg_idx_t;

    // jal always links through r31
    localparam reg_idx_t LINK_REG = 5'd31;

    // decoded opcodes, anything not listed executes as nop
    typedef enum logic [7:0] {
        OP_NOP   = 8'd0,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_ADDI, OP_ADDIU,
        OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR, OP_LUI,
        OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
        OP_CLZ, OP_CLO, OP_MOVZ, OP_MOVN,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_JAL, OP_JALR,
        // loads
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
        // stores
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR,
        // handled by cp0 further down the pipe
        OP_MFC0, OP_MTC0, OP_WAIT, OP_TLBWI, OP_TLBP, OP_ERET
    } op_e;

endpackage

// ==== rtl/ex_mem_pkg.sv ====
package ex_mem_pkg;

    // direction of the access seen by the mem stage
    typedef enum logic [1:0] {
        MEM_R2R = 2'd0,
        MEM_M2R = 2'd1,
        MEM_R2M = 2'd2
    } mem_type_e;

    // left and right are the unaligned lwl/lwr/swl/swr forms
    typedef enum logic [2:0] {
        SIZE_BYTE  = 3'd0,
        SIZE_HALF  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_LEFT  = 3'd3,
        SIZE_RIGHT = 3'd4
    } mem_size_e;

endpackage

// ==== rtl/ex_mul.sv ====
module ex_mul (
    ex_op_if.use_mul                      op_bus,
    output logic [ex_isa_pkg::HILO_W-1:0] product_o
);
    import ex_isa_pkg::*;

    logic              is_signed;
    logic              neg;
    word_t             mag_a;
    word_t             mag_b;
    logic [HILO_W-1:0] prod_mag;

    assign is_signed = (op_bus.op == OP_MUL) || (op_bus.op == OP_MULT);

    // multiply magnitudes, then restore the sign
    assign mag_a = (is_signed && op_bus.rs_val[31]) ? (~op_bus.rs_val + 32'd1) :
                   op_bus.rs_val;
    assign mag_b = (is_signed && op_bus.rt_val[31]) ? (~op_bus.rt_val + 32'd1) :
                   op_bus.rt_val;

    assign prod_mag = {32'b0, mag_a} * {32'b0, mag_b};

    assign neg = is_signed && (op_bus.rs_val[31] ^ op_bus.rt_val[31]);

    assign product_o = neg ? (~prod_mag + 64'd1) : prod_mag;

endmodule

// ==== rtl/ex_op_if.sv ====
interface ex_op_if;
    import ex_isa_pkg::*;

    op_e         op;
    word_t       rs_val;
    word_t       rt_val;
    logic [15:0] imm;
    logic [4:0]  shamt;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    word_t       link_addr;

    modport src (
        output op, rs_val, rt_val, imm, shamt, rs, rt, rd, link_addr
    );

    // alu, hilo and agen work on operands only
    modport use_alu (input op, rs_val, rt_val, imm, shamt);

    modport use_mul (input op, rs_val, rt_val);

    modport use_wb (input op, rt_val, rs, rt, rd, link_addr);

endinterface

// ==== rtl/ex_top.sv ====
module ex_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ex_isa_pkg::op_e        op_i,
    input  ex_isa_pkg::reg_idx_t   rs_i,
    input  ex_isa_pkg::reg_idx_t   rt_i,
    input  ex_isa_pkg::reg_idx_t   rd_i,
    input  ex_isa_pkg::word_t      rs_val_i,
    input  ex_isa_pkg::word_t      rt_val_i,
    input  logic [15:0]            imm_i,
    input  logic [4:0]             shamt_i,
    input  ex_isa_pkg::word_t      link_addr_i,
    output ex_isa_pkg::word_t      result_o,
    output ex_isa_pkg::reg_idx_t   dest_o,
    output logic                   overflow_o,
    output logic                   priv_o,
    output ex_mem_pkg::mem_type_e  mem_type_o,
    output ex_mem_pkg::mem_size_e  mem_size_o,
    output logic                   mem_signed_o,
    output ex_isa_pkg::word_t      mem_addr_o
);
    import ex_isa_pkg::*;

    ex_op_if op_bus ();

    word_t             alu_val;
    logic              alu_wr;
    logic              alu_ov;
    logic [HILO_W-1:0] product;
    word_t             hi;
    word_t             lo;

    // decoded instruction onto the shared bus
    assign op_bus.op        = op_i;
    assign op_bus.rs_val    = rs_val_i;
    assign op_bus.rt_val    = rt_val_i;
    assign op_bus.imm       = imm_i;
    assign op_bus.shamt     = shamt_i;
    assign op_bus.rs        = rs_i;
    assign op_bus.rt        = rt_i;
    assign op_bus.rd        = rd_i;
    assign op_bus.link_addr = link_addr_i;

    ex_alu u_alu (
        .op_bus    (op_bus.use_alu),
        .alu_val_o (alu_val),
        .alu_wr_o  (alu_wr),
        .alu_ov_o  (alu_ov)
    );

    ex_mul u_mul (
        .op_bus    (op_bus.use_mul),
        .product_o (product)
    );

    ex_hilo u_hilo (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_bus    (op_bus.use_alu),
        .product_i (product),
        .hi_o      (hi),
        .lo_o      (lo)
    );

    ex_agen u_agen (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_bus       (op_bus.use_alu),
        .mem_type_o   (mem_type_o),
        .mem_size_o   (mem_size_o),
        .mem_signed_o (mem_signed_o),
        .mem_addr_o   (mem_addr_o)
    );

    ex_writeback u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_bus     (op_bus.use_wb),
        .alu_val_i  (alu_val),
        .alu_wr_i   (alu_wr),
        .alu_ov_i   (alu_ov),
        .product_i  (product),
        .hi_i       (hi),
        .lo_i       (lo),
        .result_o   (result_o),
        .dest_o     (dest_o),
        .overflow_o (overflow_o),
        .priv_o     (priv_o)
    );

endmodule

// ==== rtl/ex_writeback.sv ====
module ex_writeback (
    input  logic                          clk,
    input  logic                          rst_n,
    ex_op_if.use_wb                       op_bus,
    input  ex_isa_pkg::word_t             alu_val_i,
    input  logic                          alu_wr_i,
    input  logic                          alu_ov_i,
    input  logic [ex_isa_pkg::HILO_W-1:0] product_i,
    input  ex_isa_pkg::word_t             hi_i,
    input  ex_isa_pkg::word_t             lo_i,
    output ex_isa_pkg::word_t             result_o,
    output ex_isa_pkg::reg_idx_t          dest_o,
    output logic                          overflow_o,
    output logic                          priv_o
);
    import ex_isa_pkg::*;

    word_t    nxt_result;
    reg_idx_t nxt_dest;
    logic     nxt_priv;

    always_comb
    begin
        nxt_result = '0;
        nxt_dest   = '0;
        nxt_priv   = 1'b0;
        case (op_bus.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
            OP_AND, OP_OR, OP_XOR, OP_NOR,
            OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
            OP_CLZ, OP_CLO, OP_MOVZ, OP_MOVN:
            begin
                nxt_result = alu_val_i;
                nxt_dest   = op_bus.rd;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                nxt_result = alu_val_i;
                nxt_dest   = op_bus.rt;
            end
            OP_MUL:
            begin
                nxt_result = product_i[31:0];
                nxt_dest   = op_bus.rd;
            end
            OP_MFHI:
            begin
                nxt_result = hi_i;
                nxt_dest   = op_bus.rd;
            end
            OP_MFLO:
            begin
                nxt_result = lo_i;
                nxt_dest   = op_bus.rd;
            end
            OP_JAL:
            begin
                nxt_result = op_bus.link_addr;
                nxt_dest   = LINK_REG;
            end
            OP_JALR:
            begin
                nxt_result = op_bus.link_addr;
                nxt_dest   = op_bus.rd;
            end
            // load target is rt
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR:
            begin
                nxt_result = op_bus.rt_val;
                nxt_dest   = op_bus.rt;
            end
            // store data rides on the result, no register write
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR:
                nxt_result = op_bus.rt_val;
            OP_MFC0, OP_MTC0, OP_WAIT, OP_TLBWI, OP_TLBP, OP_ERET:
                nxt_priv = 1'b1;
            default:
                nxt_dest = '0;
        endcase
        // overflow or failed movz/movn
        if (!alu_wr_i)
            nxt_dest = '0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            result_o   <= '0;
            dest_o     <= '0;
            overflow_o <= 1'b0;
            priv_o     <= 1'b0;
        end
        else
        begin
            result_o   <= nxt_result;
            dest_o     <= nxt_dest;
            overflow_o <= alu_ov_i;
            priv_o     <= nxt_priv;
        end
    end

endmodule
